// ==== logic/game_pkg.sv ====
package game_pkg;

    localparam int board_width = 10;
    localparam int coord_w     = 4;
    localparam int troop_w     = 9;

    typedef enum logic [1:0] {NPC, RED, BLUE} player_t;
    typedef enum logic [1:0] {TERRITORY, MOUNTAIN, CROWN, CITY} piece_t;

    // bit 1 set means a move mode
    typedef enum logic [1:0] {
        CHOOSE     = 2'b00,
        MOVE_TOTAL = 2'b10,
        MOVE_HALF  = 2'b11
    } cursor_mode_t;

    typedef enum logic [2:0] {
        W     = 3'd0,
        A     = 3'd1,
        S     = 3'd2,
        D     = 3'd3,
        SPACE = 3'd4,
        Z     = 3'd5,
        NONE  = 3'd6    // nothing pending
    } key_op_t;

    // start layout
    localparam int red_crown_h        = 2;
    localparam int red_crown_v        = 3;
    localparam int blue_crown_h       = 8;
    localparam int blue_crown_v       = 7;
    localparam int red_crown_troop    = 87;
    localparam int blue_crown_troop   = 89;
    localparam int city_h             = 1;
    localparam int city_v             = 3;
    localparam int neutral_city_troop = 67;
    localparam int mountain_0_h       = 3;
    localparam int mountain_0_v       = 3;
    localparam int mountain_1_h       = 2;
    localparam int mountain_1_v       = 4;

    function automatic player_t start_owner(int h, int v);
        if (h == red_crown_h && v == red_crown_v) return RED;
        if (h == blue_crown_h && v == blue_crown_v) return BLUE;
        return NPC;
    endfunction

    function automatic piece_t start_piece(int h, int v);
        if ((h == red_crown_h && v == red_crown_v) || (h == blue_crown_h && v == blue_crown_v))
            return CROWN;
        if (h == city_h && v == city_v) return CITY;
        if ((h == mountain_0_h && v == mountain_0_v) || (h == mountain_1_h && v == mountain_1_v))
            return MOUNTAIN;
        return TERRITORY;
    endfunction

    function automatic logic [troop_w-1:0] start_troop(int h, int v);
        if (h == red_crown_h && v == red_crown_v) return troop_w'(red_crown_troop);
        if (h == blue_crown_h && v == blue_crown_v) return troop_w'(blue_crown_troop);
        if (h == city_h && v == city_v) return troop_w'(neutral_city_troop);
        return '0;  // empty land and mountains
    endfunction

endpackage

// ==== logic/key_latch.sv ====
module key_latch (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             keyboard_ready,
    input  logic [2:0]       keyboard_data,
    input  logic             op_done,
    output logic             keyboard_read_fin,
    output game_pkg::key_op_t pending_op,
    output logic             game_run
);
    import game_pkg::*;

    // game logic only runs while the keyboard side is idle
    assign game_run = ~keyboard_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            keyboard_read_fin <= 1'b0;
            pending_op        <= NONE;
        end else begin
            keyboard_read_fin <= keyboard_ready;    // ack one cycle behind ready
            if (keyboard_ready) begin
                // a newer key replaces one still pending
                if (keyboard_data <= 3'd5) begin
                    pending_op <= key_op_t'(keyboard_data);
                end
            end else if (op_done) begin
                pending_op <= NONE;
            end
        end
    end

endmodule

// ==== logic/cursor_control.sv ====
module cursor_control #(
    parameter int board_width = game_pkg::board_width,
    parameter int coord_w     = game_pkg::coord_w
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  game_pkg::key_op_t             pending_op,
    input  logic                          game_run,
    input  game_pkg::player_t             src_owner,
    input  logic [game_pkg::troop_w-1:0]  src_troop,
    input  logic                          move_done,
    output logic                          op_done,
    output logic                          move_req,
    output logic [coord_w-1:0]            cursor_h,
    output logic [coord_w-1:0]            cursor_v,
    output logic [coord_w-1:0]            target_h,
    output logic [coord_w-1:0]            target_v,
    output game_pkg::cursor_mode_t        cursor_mode,
    output game_pkg::player_t             current_player
);
    import game_pkg::*;

    logic               target_ok;      // direction op with a neighbour on the board
    player_t            next_player;
    logic [coord_w-1:0] crown_h;
    logic [coord_w-1:0] crown_v;

    // neighbour cell in the direction of the pending key
    always_comb begin
        target_h  = cursor_h;
        target_v  = cursor_v;
        target_ok = 1'b0;
        case (pending_op)
            W: if (cursor_v != '0) begin
                target_v  = cursor_v - coord_w'(1);
                target_ok = 1'b1;
            end
            A: if (cursor_h != '0) begin
                target_h  = cursor_h - coord_w'(1);
                target_ok = 1'b1;
            end
            S: if (cursor_v < coord_w'(board_width - 1)) begin
                target_v  = cursor_v + coord_w'(1);
                target_ok = 1'b1;
            end
            D: if (cursor_h < coord_w'(board_width - 1)) begin
                target_h  = cursor_h + coord_w'(1);
                target_ok = 1'b1;
            end
            default: ;
        endcase
    end

    assign op_done  = game_run && (pending_op != NONE);
    assign move_req = op_done && (cursor_mode != CHOOSE) && target_ok;

    // two players alternate
    assign next_player = (current_player == RED) ? BLUE : RED;
    assign crown_h     = (next_player == RED) ? coord_w'(red_crown_h) : coord_w'(blue_crown_h);
    assign crown_v     = (next_player == RED) ? coord_w'(red_crown_v) : coord_w'(blue_crown_v);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cursor_h       <= '0;
            cursor_v       <= '0;
            cursor_mode    <= CHOOSE;
            current_player <= RED;
        end else if (move_done) begin
            // turn over, jump to the other crown
            current_player <= next_player;
            cursor_h       <= crown_h;
            cursor_v       <= crown_v;
            cursor_mode    <= CHOOSE;
        end else if (op_done) begin
            case (cursor_mode)
                CHOOSE: begin
                    case (pending_op)
                        W, A, S, D: begin
                            cursor_h <= target_h;   // stays put at the edge
                            cursor_v <= target_v;
                        end
                        SPACE: begin
                            if (src_owner == current_player && src_troop > 1) begin
                                cursor_mode <= MOVE_TOTAL;
                            end
                        end
                        default: ;  // Z has no meaning here
                    endcase
                end
                MOVE_TOTAL, MOVE_HALF: begin
                    case (pending_op)
                        Z:       cursor_mode <= (cursor_mode == MOVE_TOTAL) ? MOVE_HALF : MOVE_TOTAL;
                        SPACE:   cursor_mode <= CHOOSE;
                        default: ;  // directions go out as move_req
                    endcase
                end
                default: cursor_mode <= CHOOSE;
            endcase
        end
    end

endmodule

// ==== logic/board_store.sv ====
module board_store #(
    parameter int board_width = game_pkg::board_width,
    parameter int coord_w     = game_pkg::coord_w,
    parameter int troop_w     = game_pkg::troop_w
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [coord_w-1:0]   rd_a_h,
    input  logic [coord_w-1:0]   rd_a_v,
    input  logic [coord_w-1:0]   rd_b_h,
    input  logic [coord_w-1:0]   rd_b_v,
    output game_pkg::player_t    a_owner,
    output game_pkg::player_t    b_owner,
    output game_pkg::piece_t     a_piece,
    output game_pkg::piece_t     b_piece,
    output logic [troop_w-1:0]   a_troop,
    output logic [troop_w-1:0]   b_troop,
    input  logic                 wr_en,
    input  game_pkg::player_t    dst_owner_new,
    input  logic [troop_w-1:0]   src_troop_new,
    input  logic [troop_w-1:0]   dst_troop_new
);
    import game_pkg::*;

    // indexed [h][v]
    player_t            owner [board_width][board_width];
    piece_t             piece [board_width][board_width];
    logic [troop_w-1:0] troop [board_width][board_width];

    // port A is the cursor cell, port B the move target
    assign a_owner = owner[rd_a_h][rd_a_v];
    assign a_piece = piece[rd_a_h][rd_a_v];
    assign a_troop = troop[rd_a_h][rd_a_v];
    assign b_owner = owner[rd_b_h][rd_b_v];
    assign b_piece = piece[rd_b_h][rd_b_v];
    assign b_troop = troop[rd_b_h][rd_b_v];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int h = 0; h < board_width; h++) begin
                for (int v = 0; v < board_width; v++) begin
                    owner[h][v] <= start_owner(h, v);
                    piece[h][v] <= start_piece(h, v);
                    troop[h][v] <= troop_w'(start_troop(h, v));
                end
            end
        end else if (wr_en) begin
            // piece types never change, a capture only moves owner and troops
            troop[rd_a_h][rd_a_v] <= src_troop_new;
            owner[rd_b_h][rd_b_v] <= dst_owner_new;
            troop[rd_b_h][rd_b_v] <= dst_troop_new;
        end
    end

endmodule

// ==== logic/move_resolver.sv ====
module move_resolver #(
    parameter int troop_w = game_pkg::troop_w
) (
    input  logic                    move_req,
    input  game_pkg::cursor_mode_t  cursor_mode,
    input  game_pkg::player_t       current_player,
    input  logic [troop_w-1:0]      src_troop,
    input  logic [troop_w-1:0]      dst_troop,
    input  game_pkg::player_t       dst_owner,
    input  game_pkg::piece_t        dst_piece,
    output logic                    move_done,
    output game_pkg::player_t       dst_owner_new,
    output logic [troop_w-1:0]      src_troop_new,
    output logic [troop_w-1:0]      dst_troop_new
);
    import game_pkg::*;

    logic [troop_w-1:0] half;
    logic [troop_w-1:0] moved;      // troops that land on the target
    logic               open_cell;

    assign half = src_troop >> 1;

    always_comb begin
        if (cursor_mode == MOVE_TOTAL) begin
            moved         = src_troop - troop_w'(1);
            src_troop_new = troop_w'(1);   // one stays behind
        end else begin
            moved         = half;
            src_troop_new = src_troop - half;
        end
    end

    // neutral land or neutral city, mountains and owned cells block
    assign open_cell = (dst_owner == NPC) && (dst_piece == TERRITORY || dst_piece == CITY);

    // the moving force has to outnumber any neutral garrison
    assign move_done     = move_req && open_cell && (moved > dst_troop);
    assign dst_owner_new = current_player;
    assign dst_troop_new = moved;

endmodule

// ==== logic/game_player.sv ====
module game_player #(
    parameter int board_width = game_pkg::board_width,
    parameter int coord_w     = game_pkg::coord_w,
    parameter int troop_w     = game_pkg::troop_w
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    keyboard_ready,
    input  logic [2:0]              keyboard_data,
    output logic                    keyboard_read_fin,
    output logic [coord_w-1:0]      cursor_h,
    output logic [coord_w-1:0]      cursor_v,
    output game_pkg::player_t       cell_owner,
    output game_pkg::piece_t        cell_piece,
    output logic [troop_w-1:0]      cell_troop,
    output game_pkg::player_t       current_player,
    output game_pkg::cursor_mode_t  cursor_mode
);
    import game_pkg::*;

    key_op_t            pending_op;
    logic               game_run;
    logic               op_done;
    logic               move_req;
    logic               move_done;
    logic [coord_w-1:0] target_h;
    logic [coord_w-1:0] target_v;
    player_t            b_owner;
    piece_t             b_piece;
    logic [troop_w-1:0] b_troop;
    player_t            dst_owner_new;
    logic [troop_w-1:0] src_troop_new;
    logic [troop_w-1:0] dst_troop_new;

    key_latch u_key_latch (
        .clock             (clock),
        .rst_n             (rst_n),
        .keyboard_ready    (keyboard_ready),
        .keyboard_data     (keyboard_data),
        .op_done           (op_done),
        .keyboard_read_fin (keyboard_read_fin),
        .pending_op        (pending_op),
        .game_run          (game_run)
    );

    cursor_control #(
        .board_width (board_width),
        .coord_w     (coord_w)
    ) u_cursor_control (
        .clock          (clock),
        .rst_n          (rst_n),
        .pending_op     (pending_op),
        .game_run       (game_run),
        .src_owner      (cell_owner),   // cursor cell doubles as move source
        .src_troop      (cell_troop),
        .move_done      (move_done),
        .op_done        (op_done),
        .move_req       (move_req),
        .cursor_h       (cursor_h),
        .cursor_v       (cursor_v),
        .target_h       (target_h),
        .target_v       (target_v),
        .cursor_mode    (cursor_mode),
        .current_player (current_player)
    );

    board_store #(
        .board_width (board_width),
        .coord_w     (coord_w),
        .troop_w     (troop_w)
    ) u_board_store (
        .clock         (clock),
        .rst_n         (rst_n),
        .rd_a_h        (cursor_h),
        .rd_a_v        (cursor_v),
        .rd_b_h        (target_h),
        .rd_b_v        (target_v),
        .a_owner       (cell_owner),
        .b_owner       (b_owner),
        .a_piece       (cell_piece),
        .b_piece       (b_piece),
        .a_troop       (cell_troop),
        .b_troop       (b_troop),
        .wr_en         (move_done),
        .dst_owner_new (dst_owner_new),
        .src_troop_new (src_troop_new),
        .dst_troop_new (dst_troop_new)
    );

    move_resolver #(
        .troop_w (troop_w)
    ) u_move_resolver (
        .move_req       (move_req),
        .cursor_mode    (cursor_mode),
        .current_player (current_player),
        .src_troop      (cell_troop),
        .dst_troop      (b_troop),
        .dst_owner      (b_owner),
        .dst_piece      (b_piece),
        .move_done      (move_done),
        .dst_owner_new  (dst_owner_new),
        .src_troop_new  (src_troop_new),
        .dst_troop_new  (dst_troop_new)
    );

endmodule

// ==== verification/game_checker.sv ====
module game_checker (
    input  logic                            clock,
    input  logic                            check_en,
    input  logic [game_pkg::coord_w-1:0]    exp_cursor_h,
    input  logic [game_pkg::coord_w-1:0]    exp_cursor_v,
    input  game_pkg::player_t               exp_owner,
    input  game_pkg::piece_t                exp_piece,
    input  logic [game_pkg::troop_w-1:0]    exp_troop,
    input  game_pkg::player_t               exp_player,
    input  game_pkg::cursor_mode_t          exp_mode,
    input  logic [game_pkg::coord_w-1:0]    cursor_h,
    input  logic [game_pkg::coord_w-1:0]    cursor_v,
    input  game_pkg::player_t               cell_owner,
    input  game_pkg::piece_t                cell_piece,
    input  logic [game_pkg::troop_w-1:0]    cell_troop,
    input  game_pkg::player_t               current_player,
    input  game_pkg::cursor_mode_t          cursor_mode,
    output int                              error_count,
    output int                              check_count
);
    import game_pkg::*;

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    // status ports are stable here, the op resolved two edges earlier
    always @(posedge clock) begin
        if (check_en) begin
            checks++;
            compare_value("cursor_h", int'(exp_cursor_h), int'(cursor_h));
            compare_value("cursor_v", int'(exp_cursor_v), int'(cursor_v));
            compare_value("cell_owner", int'(exp_owner), int'(cell_owner));
            compare_value("cell_piece", int'(exp_piece), int'(cell_piece));
            compare_value("cell_troop", int'(exp_troop), int'(cell_troop));
            compare_value("current_player", int'(exp_player), int'(current_player));
            compare_value("cursor_mode", int'(exp_mode), int'(cursor_mode));
        end
    end

endmodule

// ==== verification/game_player_sva.sv ====
module game_player_sva #(
    parameter int board_width = game_pkg::board_width,
    parameter int coord_w     = game_pkg::coord_w
) (
    input logic                   clock,
    input logic                   rst_n,
    input logic                   keyboard_ready,
    input logic                   keyboard_read_fin,
    input logic                   move_req,
    input game_pkg::cursor_mode_t cursor_mode,
    input logic [coord_w-1:0]     cursor_h,
    input logic [coord_w-1:0]     cursor_v
);
    import game_pkg::*;

    // ack trails ready by exactly one cycle
    fin_follows_ready: assert property (@(posedge clock) disable iff (!rst_n)
        keyboard_read_fin == $past(keyboard_ready))
        else $error("keyboard_read_fin does not follow keyboard_ready by one cycle");

    no_move_in_choose: assert property (@(posedge clock) disable iff (!rst_n)
        !(move_req && cursor_mode == CHOOSE))
        else $error("move_req raised while in CHOOSE mode");

    cursor_on_board: assert property (@(posedge clock) disable iff (!rst_n)
        cursor_h < coord_w'(board_width) && cursor_v < coord_w'(board_width))
        else $error("cursor left the board");

endmodule

// top level sees both the key latch and the cursor signals
bind game_player game_player_sva #(
    .board_width (board_width),
    .coord_w     (coord_w)
) u_sva (
    .clock             (clock),
    .rst_n             (rst_n),
    .keyboard_ready    (keyboard_ready),
    .keyboard_read_fin (keyboard_read_fin),
    .move_req          (move_req),
    .cursor_mode       (cursor_mode),
    .cursor_h          (cursor_h),
    .cursor_v          (cursor_v)
);

// ==== verification/game_player_tb.sv ====
module game_player_tb;
    import game_pkg::*;

    localparam int fin_timeout = 20;    // cycles allowed per handshake edge

    typedef struct packed {
        logic [2:0]         code;
        logic [coord_w-1:0] h;
        logic [coord_w-1:0] v;
        player_t            owner;
        piece_t             piece;
        logic [troop_w-1:0] troop;
        player_t            player;
        cursor_mode_t       mode;
    } row_t;

    logic               clock;
    logic               rst_n;
    logic               keyboard_ready;
    logic [2:0]         keyboard_data;
    logic               keyboard_read_fin;
    logic [coord_w-1:0] cursor_h;
    logic [coord_w-1:0] cursor_v;
    player_t            cell_owner;
    piece_t             cell_piece;
    logic [troop_w-1:0] cell_troop;
    player_t            current_player;
    cursor_mode_t       cursor_mode;
    logic               check_en;
    row_t               expected;
    row_t               rows [$];
    int                 error_count;
    int                 check_count;
    int                 timeout_count = 0;

    game_player dut (
        .clock             (clock),
        .rst_n             (rst_n),
        .keyboard_ready    (keyboard_ready),
        .keyboard_data     (keyboard_data),
        .keyboard_read_fin (keyboard_read_fin),
        .cursor_h          (cursor_h),
        .cursor_v          (cursor_v),
        .cell_owner        (cell_owner),
        .cell_piece        (cell_piece),
        .cell_troop        (cell_troop),
        .current_player    (current_player),
        .cursor_mode       (cursor_mode)
    );

    game_checker u_checker (
        .clock          (clock),
        .check_en       (check_en),
        .exp_cursor_h   (expected.h),
        .exp_cursor_v   (expected.v),
        .exp_owner      (expected.owner),
        .exp_piece      (expected.piece),
        .exp_troop      (expected.troop),
        .exp_player     (expected.player),
        .exp_mode       (expected.mode),
        .cursor_h       (cursor_h),
        .cursor_v       (cursor_v),
        .cell_owner     (cell_owner),
        .cell_piece     (cell_piece),
        .cell_troop     (cell_troop),
        .current_player (current_player),
        .cursor_mode    (cursor_mode),
        .error_count    (error_count),
        .check_count    (check_count)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic row_t make_row(logic [2:0] code, int h, int v, player_t owner,
                                      piece_t piece, int troop, player_t player,
                                      cursor_mode_t mode);
        row_t r;
        r.code   = code;
        r.h      = coord_w'(h);
        r.v      = coord_w'(v);
        r.owner  = owner;
        r.piece  = piece;
        r.troop  = troop_w'(troop);
        r.player = player;
        r.mode   = mode;
        return r;
    endfunction

    // key, then the cursor cell and game state expected after it
    task automatic load_table;
        rows.push_back(make_row(W, 0, 0, NPC, TERRITORY, 0, RED, CHOOSE));     // top edge
        rows.push_back(make_row(A, 0, 0, NPC, TERRITORY, 0, RED, CHOOSE));     // left edge
        rows.push_back(make_row(D, 1, 0, NPC, TERRITORY, 0, RED, CHOOSE));
        rows.push_back(make_row(S, 1, 1, NPC, TERRITORY, 0, RED, CHOOSE));
        rows.push_back(make_row(S, 1, 2, NPC, TERRITORY, 0, RED, CHOOSE));
        rows.push_back(make_row(S, 1, 3, NPC, CITY, 67, RED, CHOOSE));
        rows.push_back(make_row(SPACE, 1, 3, NPC, CITY, 67, RED, CHOOSE));    // not ours
        rows.push_back(make_row(D, 2, 3, RED, CROWN, 87, RED, CHOOSE));
        rows.push_back(make_row(SPACE, 2, 3, RED, CROWN, 87, RED, MOVE_TOTAL));
        rows.push_back(make_row(Z, 2, 3, RED, CROWN, 87, RED, MOVE_HALF));
        rows.push_back(make_row(Z, 2, 3, RED, CROWN, 87, RED, MOVE_TOTAL));
        rows.push_back(make_row(SPACE, 2, 3, RED, CROWN, 87, RED, CHOOSE));
        rows.push_back(make_row(SPACE, 2, 3, RED, CROWN, 87, RED, MOVE_TOTAL));
        rows.push_back(make_row(D, 2, 3, RED, CROWN, 87, RED, MOVE_TOTAL));   // mountain
        rows.push_back(make_row(S, 2, 3, RED, CROWN, 87, RED, MOVE_TOTAL));   // mountain
        rows.push_back(make_row(Z, 2, 3, RED, CROWN, 87, RED, MOVE_HALF));
        rows.push_back(make_row(W, 8, 7, BLUE, CROWN, 89, BLUE, CHOOSE));     // 87 split 43/44
        rows.push_back(make_row(SPACE, 8, 7, BLUE, CROWN, 89, BLUE, MOVE_TOTAL));
        rows.push_back(make_row(D, 2, 3, RED, CROWN, 44, RED, CHOOSE));       // 88 onto (9,7)
        rows.push_back(make_row(W, 2, 2, RED, TERRITORY, 43, RED, CHOOSE));
        rows.push_back(make_row(SPACE, 2, 2, RED, TERRITORY, 43, RED, MOVE_TOTAL));
        rows.push_back(make_row(W, 8, 7, BLUE, CROWN, 1, BLUE, CHOOSE));
        rows.push_back(make_row(D, 9, 7, BLUE, TERRITORY, 88, BLUE, CHOOSE));
        rows.push_back(make_row(3'd6, 9, 7, BLUE, TERRITORY, 88, BLUE, CHOOSE));
        rows.push_back(make_row(3'd7, 9, 7, BLUE, TERRITORY, 88, BLUE, CHOOSE));
        rows.push_back(make_row(D, 9, 7, BLUE, TERRITORY, 88, BLUE, CHOOSE));  // right edge
        rows.push_back(make_row(S, 9, 8, NPC, TERRITORY, 0, BLUE, CHOOSE));
        rows.push_back(make_row(S, 9, 9, NPC, TERRITORY, 0, BLUE, CHOOSE));
        rows.push_back(make_row(S, 9, 9, NPC, TERRITORY, 0, BLUE, CHOOSE));    // bottom edge
    endtask

    task automatic press_key(input logic [2:0] code);
        @(posedge clock);
        keyboard_ready <= 1'b1;
        keyboard_data  <= code;
        @(posedge clock);
        keyboard_ready <= 1'b0;     // one cycle of ready
    endtask

    task automatic wait_read_fin(input logic level, output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < fin_timeout) begin
            @(posedge clock);
            if (keyboard_read_fin == level) begin
                ok = 1'b1;
            end
            n++;
        end
        if (!ok) begin
            $display("timeout: keyboard_read_fin did not go to %0b within %0d cycles",
                     level, fin_timeout);
            timeout_count++;
        end
    endtask

    task automatic request_check(input row_t r);
        expected <= r;
        check_en <= 1'b1;
        @(posedge clock);
        check_en <= 1'b0;
    endtask

    initial begin
        logic ok;
        rst_n          = 1'b0;
        keyboard_ready = 1'b0;
        keyboard_data  = 3'd0;
        check_en       = 1'b0;
        expected       = '0;
        load_table();
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        request_check(make_row(3'd6, 0, 0, NPC, TERRITORY, 0, RED, CHOOSE));   // reset state
        ok = 1'b1;
        foreach (rows[i]) begin
            if (ok) begin
                press_key(rows[i].code);
                wait_read_fin(1'b1, ok);
                if (ok) begin
                    wait_read_fin(1'b0, ok);    // falling edge marks the new state
                end
                if (ok) begin
                    request_check(rows[i]);
                end
            end
        end
        @(posedge clock);
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count == rows.size() + 1) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== game_player.f ====
logic/game_pkg.sv
logic/key_latch.sv
logic/cursor_control.sv
logic/board_store.sv
logic/move_resolver.sv
logic/game_player.sv
verification/game_checker.sv
verification/game_player_sva.sv
verification/game_player_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module game_player_tb -f game_player.f
./obj_dir/Vgame_player_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation PASSED" sim.log
